//--- include/distrib_cfg.svh
`ifndef DISTRIB_CFG_SVH
`define DISTRIB_CFG_SVH

// **************************************************
// Issue distribution sizing
// **************************************************

// Decoded slots per bundle
`define SLOT_COUNT 10

// Ports per issue group
`define GROUP_PORTS 3

// Memory, ALU and shift groups together
`define PORT_COUNT 9

`endif

//--- hdl/distrib_pkg.sv
`include "distrib_cfg.svh"

package distrib_pkg;

  // **************************************************
  // Slot classes
  // **************************************************

  typedef enum logic [2:0] {
    CLS_NONE  = 3'd0,
    CLS_LOAD  = 3'd1,
    CLS_STORE = 3'd2,
    CLS_ALU   = 3'd3,
    CLS_SHIFT = 3'd4
  } slot_class_e;

  typedef slot_class_e [`SLOT_COUNT-1:0] slot_bundle_t; // Slot 0 in the low bits

  typedef logic [`SLOT_COUNT-1:0] slot_mask_t;

  // One-hot slot position, all ones when the port is idle
  typedef logic [`SLOT_COUNT-1:0] port_pos_t;

  typedef struct packed {
    slot_mask_t load;
    slot_mask_t store;
    slot_mask_t alu;
    slot_mask_t shift;
  } class_masks_t;

  // **************************************************
  // Port groups
  // **************************************************

  typedef struct packed {
    port_pos_t [`GROUP_PORTS-1:0] entry; // Entry 0 is the oldest slot
    logic [1:0]                   count; // Granted entries, 0 to 3
  } port_group_t;

  typedef logic [`GROUP_PORTS-1:0] rot_ptr_t; // One-hot group port

endpackage

//--- hdl/slot_classifier.sv
`include "distrib_cfg.svh"

module slot_classifier (
  input  distrib_pkg::slot_bundle_t bundle,
  output distrib_pkg::class_masks_t masks
);

  import distrib_pkg::*;

  always_comb begin
    masks = '0;
    for (int i = 0; i < `SLOT_COUNT; i++) begin
      case (bundle[i])
        CLS_LOAD:  masks.load[i]  = 1'b1;
        CLS_STORE: masks.store[i] = 1'b1;
        CLS_ALU:   masks.alu[i]   = 1'b1;
        CLS_SHIFT: masks.shift[i] = 1'b1;
        default:   ; // Empty or unknown slot
      endcase
    end
  end

  // **************************************************
  // Checks
  // **************************************************

  // A slot feeds one issue group at most
  always_comb begin
    assert final (
      ((masks.load  & masks.store) == '0) &&
      ((masks.load  & masks.alu)   == '0) &&
      ((masks.load  & masks.shift) == '0) &&
      ((masks.store & masks.alu)   == '0) &&
      ((masks.store & masks.shift) == '0) &&
      ((masks.alu   & masks.shift) == '0)
    ) else begin
      $error("slot_classifier: class masks overlap");
    end
  end

endmodule

//--- hdl/slot_picker.sv
`include "distrib_cfg.svh"

module slot_picker (
  input  distrib_pkg::slot_mask_t  mask,
  output distrib_pkg::port_group_t group
);

  import distrib_pkg::*;

  localparam int CW = $clog2(`SLOT_COUNT + 1);

  logic [`SLOT_COUNT:0][CW-1:0] prefix; // Set bits below each slot

  always_comb begin
    prefix[0] = '0;
    for (int k = 0; k < `SLOT_COUNT; k++) begin
      prefix[k+1] = prefix[k] + CW'(mask[k]);
    end
  end

  // Slot k is entry j when it is set and j set bits sit below it
  for (genvar j = 0; j < `GROUP_PORTS; j++) begin : g_entry
    port_pos_t hit;

    for (genvar k = 0; k < `SLOT_COUNT; k++) begin : g_slot
      assign hit[k] = mask[k] && (prefix[k] == CW'(j));
    end

    assign group.entry[j] = (prefix[`SLOT_COUNT] > CW'(j)) ? hit : '1; // Idle when unfilled
  end

  assign group.count = (prefix[`SLOT_COUNT] > CW'(`GROUP_PORTS)) ? 2'd3 :
                       prefix[`SLOT_COUNT][1:0];

  // **************************************************
  // Checks
  // **************************************************

  always_comb begin
    for (int j = 0; j < `GROUP_PORTS; j++) begin
      assert final ($onehot(group.entry[j]) || (&group.entry[j]))
      else begin
        $error("slot_picker: entry %0d is %b", j, group.entry[j]);
      end
    end
  end

endmodule

//--- hdl/port_allocator.sv
`include "distrib_cfg.svh"

module port_allocator (
  input  distrib_pkg::class_masks_t masks,
  output distrib_pkg::port_group_t  mem_group,
  output distrib_pkg::port_group_t  alu_group,
  output distrib_pkg::port_group_t  shift_group,
  output logic                      overflow
);

  import distrib_pkg::*;

  localparam int CW = $clog2(`SLOT_COUNT + 1);

  port_group_t store_group;
  port_group_t load_group;
  logic [2:0]  mem_sum;

  logic [CW-1:0] store_pop;
  logic [CW-1:0] load_pop;
  logic [CW-1:0] alu_pop;
  logic [CW-1:0] shift_pop;

  slot_picker store_pick_i (
    .mask  (masks.store),
    .group (store_group)
  );

  slot_picker load_pick_i (
    .mask  (masks.load),
    .group (load_group)
  );

  slot_picker alu_pick_i (
    .mask  (masks.alu),
    .group (alu_group)
  );

  slot_picker shift_pick_i (
    .mask  (masks.shift),
    .group (shift_group)
  );

  // **************************************************
  // Memory group with stores ahead of loads
  // **************************************************

  assign mem_sum = {1'b0, store_group.count} + {1'b0, load_group.count};

  always_comb begin
    for (int i = 0; i < `GROUP_PORTS; i++) begin
      if (i < int'(store_group.count)) begin
        mem_group.entry[i] = store_group.entry[i];
      end else begin
        mem_group.entry[i] = load_group.entry[i - int'(store_group.count)]; // Loads fill after stores
      end
    end
    mem_group.count = (mem_sum > 3'd3) ? 2'd3 : mem_sum[1:0];
  end

  // Full populations since the group counts saturate
  assign store_pop = CW'($countones(masks.store));
  assign load_pop  = CW'($countones(masks.load));
  assign alu_pop   = CW'($countones(masks.alu));
  assign shift_pop = CW'($countones(masks.shift));

  assign overflow = ((int'(store_pop) + int'(load_pop)) > `GROUP_PORTS) ||
                    (int'(alu_pop) > `GROUP_PORTS) ||
                    (int'(shift_pop) > `GROUP_PORTS);

endmodule

//--- hdl/port_rotator.sv
`include "distrib_cfg.svh"

module port_rotator (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic                                         stall,
  input  distrib_pkg::port_group_t                     group,
  output distrib_pkg::port_pos_t [`GROUP_PORTS-1:0]    ports
);

  import distrib_pkg::*;

  rot_ptr_t ptr;
  rot_ptr_t ptr_next;

  // Entry i lands on group port (ptr + i) mod 3
  always_comb begin
    ports = '1;
    for (int p = 0; p < `GROUP_PORTS; p++) begin
      if (ptr[p]) begin
        for (int i = 0; i < `GROUP_PORTS; i++) begin
          ports[(p + i) % `GROUP_PORTS] = group.entry[i];
        end
      end
    end
  end

  // **************************************************
  // Pointer advance by granted count mod 3
  // **************************************************

  always_comb begin
    case (group.count)
      2'd1:    ptr_next = {ptr[1:0], ptr[2]};
      2'd2:    ptr_next = {ptr[0], ptr[2:1]};
      default: ptr_next = ptr; // Zero or a full turn
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= rot_ptr_t'(1); // Group port 0
    end else if (!stall) begin
      ptr <= ptr_next;
    end
  end

  // **************************************************
  // Checks
  // **************************************************

  ptr_onehot_a: assert property (
    @(posedge clk) disable iff (rst) $onehot(ptr)
  ) else $error("port_rotator: pointer %b lost its one-hot form", ptr);

endmodule

//--- hdl/issue_distrib.sv
`include "distrib_cfg.svh"

module issue_distrib (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       stall,
  input  distrib_pkg::slot_bundle_t                  bundle,
  output distrib_pkg::port_pos_t [`PORT_COUNT-1:0]   ports,
  output logic                                       overflow
);

  import distrib_pkg::*;

  class_masks_t masks;
  port_group_t  mem_group;
  port_group_t  alu_group;
  port_group_t  shift_group;

  slot_classifier classifier_i (
    .bundle (bundle),
    .masks  (masks)
  );

  port_allocator allocator_i (
    .masks       (masks),
    .mem_group   (mem_group),
    .alu_group   (alu_group),
    .shift_group (shift_group),
    .overflow    (overflow)
  );

  // **************************************************
  // Port groups
  // **************************************************

  port_rotator mem_rot_i (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .group (mem_group),
    .ports (ports[2:0])
  );

  assign ports[5:3] = alu_group.entry; // ALU group is not rotated

  port_rotator shift_rot_i (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .group (shift_group),
    .ports (ports[8:6])
  );

endmodule

//--- verif/tb_issue_distrib.sv
`include "distrib_cfg.svh"

module tb_issue_distrib;

  import distrib_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 16;
  localparam int          CASE_FIELDS  = 21;
  localparam logic [3:0]  SLOT_IDLE    = 4'hf; // Idle marker in the data file

  typedef struct packed {
    logic                        stall;
    slot_bundle_t                bundle;
    logic [`PORT_COUNT-1:0][3:0] slot_num; // Expected slot per port
    logic                        overflow;
  } issue_case_t;

  logic                             clk;
  logic                             rst;
  logic                             stall;
  slot_bundle_t                     bundle;
  port_pos_t [`PORT_COUNT-1:0]      ports;
  logic                             overflow;

  issue_case_t cases[$];
  int          cycle_count = 0;
  int          cycle_limit = 0;

  issue_distrib dut_i (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .bundle   (bundle),
    .ports    (ports),
    .overflow (overflow)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // **************************************************
  // Failure handling and checks
  // **************************************************

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h",
                         $time, name, actual, expected));
    end
  endtask

  function automatic port_pos_t decode_slot_pos(input logic [3:0] num);
    if (num == SLOT_IDLE) begin
      return '1;
    end
    return port_pos_t'(1) << num; // One-hot slot position
  endfunction

  // **************************************************
  // Case file
  // **************************************************

  task automatic load_cases();
    issue_case_t tc;
    int          fd;
    int          n;
    string       line;
    int          f[CASE_FIELDS];
    fd = $fopen("verif/issue_cases.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the case file verif/issue_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() == 0 || line[0] == "#") begin
        continue; // Column notes
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                  f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
      if (n == CASE_FIELDS) begin
        tc.stall = 1'(f[0]);
        for (int s = 0; s < `SLOT_COUNT; s++) begin
          tc.bundle[s] = slot_class_e'(f[1 + s]);
        end
        for (int p = 0; p < `PORT_COUNT; p++) begin
          tc.slot_num[p] = 4'(f[1 + `SLOT_COUNT + p]);
        end
        tc.overflow = 1'(f[CASE_FIELDS - 1]);
        cases.push_back(tc);
      end else if (n > 0) begin
        fail_run($sformatf("Case file line has %0d fields instead of %0d: %s",
                           n, CASE_FIELDS, line));
      end
    end
    $fclose(fd);
    if (cases.size() == 0) begin
      fail_run("The case file holds no cases");
    end
  endtask

  // Drive on the rising edge, check just before the next one
  task automatic run_case(input issue_case_t tc, input int idx);
    port_pos_t exp_pos;
    @(posedge clk);
    stall  <= tc.stall;
    bundle <= tc.bundle;
    @(negedge clk);
    #(CLK_PERIOD / 2 - 10);
    for (int p = 0; p < `PORT_COUNT; p++) begin
      exp_pos = decode_slot_pos(tc.slot_num[p]);
      check_equal($sformatf("case %0d ports[%0d]", idx, p), ports[p], exp_pos);
    end
    check_equal($sformatf("case %0d overflow", idx), overflow, tc.overflow);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      fail_run($sformatf("Timed out after %0d cycles before all cases ran", cycle_count));
    end
  end

  initial begin
    rst    = 1'b1;
    stall  = 1'b0;
    bundle = '0;
    load_cases();
    cycle_limit = RESET_CYCLES + cases.size() + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    foreach (cases[i]) begin
      run_case(cases[i], i);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- verif/issue_cases.txt
# stall, class code of slots 0..9 (0 none, 1 load, 2 store, 3 alu, 4 shift)
# then expected slot on ports 0..8 in hex (f idle), then expected overflow
# reset and empty bundle
0  0 0 0 0 0 0 0 0 0 0  f f f f f f f f f  0
# memory order, stores before loads
0  1 2 0 2 0 0 0 0 0 0  1 3 0 f f f f f f  0
# alu and shift selection
0  3 4 3 0 4 3 0 0 0 0  f f f 0 2 5 1 4 f  0
# rotation across cases
0  0 0 0 0 0 2 0 4 0 0  5 f f f f f f f 7  0
0  4 0 1 4 0 0 1 0 3 4  f 2 6 8 f f 0 3 9  0
0  0 4 4 0 2 0 0 0 2 0  4 8 f f f f 1 2 f  0
# stall holds both pointers
1  0 0 0 1 0 4 0 0 0 0  f f 3 f f f f f 5  0
1  2 3 1 0 0 0 3 3 0 3  2 f 0 1 6 7 f f f  1
0  0 0 0 0 4 0 4 0 0 2  f f 9 f f f 6 f 4  0
# overflow and load cut
0  2 2 1 1 0 0 0 0 0 0  0 1 2 f f f f f f  1
0  1 0 1 0 0 1 0 2 4 1  7 0 2 f f f f 8 f  1
0  4 4 4 4 4 3 3 3 1 0  8 f f 5 6 7 1 2 0  1
# exactly three per group
0  3 3 3 1 1 4 4 4 0 2  4 9 3 0 1 2 6 7 5  0
1  0 0 0 0 0 0 0 0 0 0  f f f f f f f f f  0
0  3 3 3 3 3 3 3 3 3 3  f f f 0 1 2 f f f  1
# more rotation
0  1 0 0 0 0 0 0 0 0 4  f 0 f f f f f f 9  0
0  0 4 4 2 0 0 2 0 0 0  6 f 3 f f f 1 2 f  0
0  2 1 3 4 0 0 0 0 0 0  f 0 1 2 f f f f 3  0
0  0 0 0 0 4 2 0 0 0 0  5 f f f f f 4 f f  0

//--- compile.f
+incdir+include
hdl/distrib_pkg.sv
hdl/slot_classifier.sv
hdl/slot_picker.sv
hdl/port_allocator.sv
hdl/port_rotator.sv
hdl/issue_distrib.sv
verif/tb_issue_distrib.sv

//--- Bender.yml
package:
  name: issue_distrib

export_include_dirs:
  - include

sources:
  - files:
      - hdl/distrib_pkg.sv
      - hdl/slot_classifier.sv
      - hdl/slot_picker.sv
      - hdl/port_allocator.sv
      - hdl/port_rotator.sv
      - hdl/issue_distrib.sv
  - target: simulation
    files:
      - verif/tb_issue_distrib.sv
